// ==== source/m6805_params.svh ====
`ifndef M6805_PARAMS_SVH
`define M6805_PARAMS_SVH

// datapath widths of the execution slice.
`define M6805_DW 8   // data operands and memory bytes.
`define M6805_AW 13  // effective addresses and the full alu operand width.
`define M6805_BW 3   // bit number for bset and bclr.

`endif

// ==== source/m6805_pkg.sv ====
package m6805_pkg;

    // alu operation codes, one per arithmetic or logic class.
    typedef enum logic [3:0] {
        ADD_ALU  = 4'd0,
        AND_ALU  = 4'd1,
        OR_ALU   = 4'd2,
        EOR_ALU  = 4'd3,
        ASR_ALU  = 4'd4,
        LSR_ALU  = 4'd5,
        BSET_ALU = 4'd6,
        BCLR_ALU = 4'd7,
        LSL_ALU  = 4'd8,
        ROL_ALU  = 4'd9,
        ROR_ALU  = 4'd10,
        SUB_ALU  = 4'd11
    } alu_op_e;

    // carry input for add, sub and lsr.
    typedef enum logic [1:0] {
        NO_CARRY  = 2'd0,  // carry in is zero.
        CIN_CARRY = 2'd1,  // carry in comes from the C flag.
        HI_CARRY  = 2'd2   // carry in is forced to one.
    } carry_sel_e;

    // where the two operands come from.
    typedef enum logic [1:0] {
        SRC_MEM = 2'd0,  // memory data first, immediate second.
        SRC_IMM = 2'd1,  // immediate first, memory data second.
        SRC_EA  = 2'd2,  // address base plus immediate offset.
        SRC_BIT = 2'd3   // memory data and a bit number.
    } src_sel_e;

    // one bit per flag, set when the operation loads that flag.
    typedef struct packed {
        logic h;
        logic n;
        logic z;
        logic c;
    } cc_mask_t;

    function automatic cc_mask_t cc_mask_of(alu_op_e op, src_sel_e src);
        cc_mask_t m;
        m = '0;
        case (op)
            ADD_ALU: begin
                m.h = 1'b1;
                m.n = 1'b1;
                m.z = 1'b1;
                m.c = 1'b1;
            end
            SUB_ALU, ASR_ALU, LSR_ALU, LSL_ALU, ROL_ALU, ROR_ALU: begin
                m.n = 1'b1;
                m.z = 1'b1;
                m.c = 1'b1;
            end
            AND_ALU, OR_ALU, EOR_ALU: begin
                m.n = 1'b1; // logic operations leave C and H alone.
                m.z = 1'b1;
            end
            BSET_ALU, BCLR_ALU: m.c = 1'b1; // C returns the old bit value.
            default: m = '0;
        endcase
        if (src == SRC_EA) begin
            m = '0; // address arithmetic never touches the flags.
        end
        return m;
    endfunction

endpackage

// ==== source/m6805_operand_sel.sv ====
`include "m6805_params.svh"

module m6805_operand_sel (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cen,
    input  logic                    issue,
    input  m6805_pkg::alu_op_e      alu_sel,
    input  m6805_pkg::carry_sel_e   carry_sel,
    input  m6805_pkg::src_sel_e     src_sel,
    input  logic [`M6805_DW-1:0]    mem_data,
    input  logic [`M6805_DW-1:0]    imm,
    input  logic [`M6805_AW-1:0]    ea_base,
    output logic                    valid,
    output logic [`M6805_AW-1:0]    op0,
    output logic [`M6805_AW-1:0]    op1,
    output m6805_pkg::alu_op_e      alu_sel_q,
    output m6805_pkg::carry_sel_e   carry_sel_q,
    output m6805_pkg::cc_mask_t     cc_mask
);

    import m6805_pkg::*;

    logic [`M6805_AW-1:0] mem_ext;   // memory data widened to the alu width.
    logic [`M6805_AW-1:0] imm_ext;   // immediate widened to the alu width.
    logic [`M6805_AW-1:0] bit_op;    // bit number placed where the alu looks for it.
    logic [`M6805_AW-1:0] op0_d;
    logic [`M6805_AW-1:0] op1_d;

    assign mem_ext = {{(`M6805_AW-`M6805_DW){1'b0}}, mem_data};
    assign imm_ext = {{(`M6805_AW-`M6805_DW){1'b0}}, imm};

    // the bit number sits in bits 3 down to 1, as in the opcode field it comes from.
    always_comb begin
        bit_op = '0;
        bit_op[`M6805_BW:1] = imm[`M6805_BW-1:0];
    end

    always_comb begin
        case (src_sel)
            SRC_EA: begin
                op0_d = ea_base;  // indexed address base.
                op1_d = imm_ext;  // unsigned 8-bit offset.
            end
            SRC_BIT: begin
                op0_d = mem_ext;
                op1_d = bit_op;
            end
            SRC_IMM: begin
                op0_d = imm_ext;  // operands swap so the immediate is the minuend.
                op1_d = mem_ext;
            end
            default: begin
                op0_d = mem_ext;
                op1_d = imm_ext;
            end
        endcase
    end

    // control half of the operand register.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid       <= 1'b0;
            alu_sel_q   <= ADD_ALU;
            carry_sel_q <= NO_CARRY;
            cc_mask     <= '0;
        end else if (cen) begin
            valid <= issue; // one enabled cycle per accepted operation.
            if (issue) begin
                alu_sel_q   <= alu_sel;
                carry_sel_q <= carry_sel;
                cc_mask     <= cc_mask_of(alu_sel, src_sel);
            end
        end
    end

    // operand payload only moves on an accepted issue.
    always_ff @(posedge clk) begin
        if (cen && issue) begin
            op0 <= op0_d;
            op1 <= op1_d;
        end
    end

endmodule

// ==== source/m6805_alu.sv ====
`include "m6805_params.svh"

module m6805_alu (
    input  m6805_pkg::carry_sel_e   carry_sel,
    input  m6805_pkg::alu_op_e      alu_sel,
    input  logic                    cin,      // current C flag.
    input  logic                    hin,      // current H flag.
    input  logic [`M6805_AW-1:0]    op0,
    input  logic [`M6805_AW-1:0]    op1,
    output logic                    ho,
    output logic [`M6805_AW-1:0]    rslt,
    output logic [2:0]              rslt_cc   // N, Z and C in that order.
);

    import m6805_pkg::*;

    logic                   cx;      // carry in after the carry selection.
    logic                   h4;      // carry out of the low nibble.
    logic                   c8;      // carry, borrow or shifted-out bit of the low byte.
    logic                   n8;
    logic                   z8;
    logic [`M6805_BW-1:0]   bit_idx; // target bit of bset and bclr.
    logic [`M6805_AW-1:0]   res;

    assign bit_idx = op1[`M6805_BW:1];

    always_comb begin
        case (carry_sel)
            CIN_CARRY: cx = cin;
            HI_CARRY:  cx = 1'b1;
            default:   cx = 1'b0;
        endcase

        res = op0;   // upper bits pass through for byte operations.
        c8  = 1'b0;
        h4  = hin;   // H is carried along unless an add recomputes it.
        case (alu_sel)
            ADD_ALU: begin
                // nibble by nibble so the half carry falls out directly.
                {h4, res[3:0]} = {1'b0, op0[3:0]} + {1'b0, op1[3:0]} + {4'd0, cx};
                {c8, res[7:4]} = {1'b0, op0[7:4]} + {1'b0, op1[7:4]} + {4'd0, h4};
                res[12:8] = op0[12:8] + op1[12:8] + {4'd0, c8}; // address high part.
            end
            AND_ALU: res[7:0] = op0[7:0] & op1[7:0];
            OR_ALU:  res[7:0] = op0[7:0] | op1[7:0];
            EOR_ALU: res[7:0] = op0[7:0] ^ op1[7:0];
            ASR_ALU: {res[7:0], c8} = {op0[7], op0[7:0]};   // sign bit is kept.
            LSR_ALU: {res[7:0], c8} = {cx, op0[7:0]};       // cx is normally zero here.
            BSET_ALU: begin
                res[7:0]     = op0[7:0];
                res[bit_idx] = 1'b1;
                c8           = op0[bit_idx];  // old bit value goes to C.
            end
            BCLR_ALU: begin
                res[7:0]     = op0[7:0];
                res[bit_idx] = 1'b0;
                c8           = op0[bit_idx];
            end
            LSL_ALU: {c8, res[7:0]} = {op0[7:0], 1'b0};
            ROL_ALU: {c8, res[7:0]} = {op0[7:0], cin};      // rotates always go through C.
            ROR_ALU: {res[7:0], c8} = {cin, op0[7:0]};
            SUB_ALU: begin
                // c8 ends up as the borrow out of bit 7.
                {c8, res[7:0]} = {1'b0, op0[7:0]} - {1'b0, op1[7:0]} - {8'd0, cx};
            end
            default: res = op0;
        endcase

        z8 = (res[7:0] == '0);  // flags look at the data byte only.
        n8 = res[7];
    end

    assign rslt    = res;
    assign ho      = h4;
    assign rslt_cc = {n8, z8, c8};

endmodule

// ==== source/m6805_ccr.sv ====
`include "m6805_params.svh"

module m6805_ccr (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cen,
    input  logic                    valid,
    input  m6805_pkg::cc_mask_t     cc_mask,
    input  logic [`M6805_AW-1:0]    rslt,
    input  logic                    ho,
    input  logic [2:0]              rslt_cc,
    output logic                    cin,
    output logic                    hin,
    output logic [`M6805_AW-1:0]    result,
    output logic [3:0]              cc,       // H, N, Z and C in that order.
    output logic                    done
);

    logic [3:0] upd_mask;  // mask as a plain vector in the cc bit order.
    logic [3:0] cc_new;    // flags as the alu computed them.
    logic [3:0] cc_next;

    assign upd_mask = cc_mask;
    assign cc_new   = {ho, rslt_cc};

    // masked flags come from the alu, the rest keep their value.
    assign cc_next = (cc_new & upd_mask) | (cc & ~upd_mask);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
            cc     <= '0;
            done   <= 1'b0;
        end else if (cen) begin
            done <= valid;  // done holds its level while cen is low.
            if (valid) begin
                result <= rslt;
                cc     <= cc_next;
            end
        end
    end

    // the next operation reads the flags written on the previous enabled edge.
    assign cin = cc[0];
    assign hin = cc[3];

endmodule

// ==== source/m6805_exec.sv ====
`include "m6805_params.svh"

module m6805_exec (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cen,
    input  logic                    issue,
    input  m6805_pkg::alu_op_e      alu_sel,
    input  m6805_pkg::carry_sel_e   carry_sel,
    input  m6805_pkg::src_sel_e     src_sel,
    input  logic [`M6805_DW-1:0]    mem_data,
    input  logic [`M6805_DW-1:0]    imm,
    input  logic [`M6805_AW-1:0]    ea_base,
    output logic [`M6805_AW-1:0]    result,
    output logic [3:0]              cc,
    output logic                    done
);

    import m6805_pkg::*;

    logic                   valid;
    logic [`M6805_AW-1:0]   op0;
    logic [`M6805_AW-1:0]   op1;
    alu_op_e                alu_sel_q;
    carry_sel_e             carry_sel_q;
    cc_mask_t               cc_mask;
    logic [`M6805_AW-1:0]   rslt;
    logic                   ho;
    logic [2:0]             rslt_cc;
    logic                   cin;
    logic                   hin;

    // first stage, the operand register.
    m6805_operand_sel m6805_operand_sel_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .cen         (cen),
        .issue       (issue),
        .alu_sel     (alu_sel),
        .carry_sel   (carry_sel),
        .src_sel     (src_sel),
        .mem_data    (mem_data),
        .imm         (imm),
        .ea_base     (ea_base),
        .valid       (valid),
        .op0         (op0),
        .op1         (op1),
        .alu_sel_q   (alu_sel_q),
        .carry_sel_q (carry_sel_q),
        .cc_mask     (cc_mask)
    );

    // combinational between the two register stages.
    m6805_alu m6805_alu_inst (
        .carry_sel (carry_sel_q),
        .alu_sel   (alu_sel_q),
        .cin       (cin),
        .hin       (hin),
        .op0       (op0),
        .op1       (op1),
        .ho        (ho),
        .rslt      (rslt),
        .rslt_cc   (rslt_cc)
    );

    // second stage, result and flags, with C and H fed back to the alu.
    m6805_ccr m6805_ccr_inst (
        .clk     (clk),
        .arst_n  (arst_n),
        .cen     (cen),
        .valid   (valid),
        .cc_mask (cc_mask),
        .rslt    (rslt),
        .ho      (ho),
        .rslt_cc (rslt_cc),
        .cin     (cin),
        .hin     (hin),
        .result  (result),
        .cc      (cc),
        .done    (done)
    );

endmodule

// ==== tests/m6805_exec_checker.sv ====
module m6805_exec_checker (
    input logic       clk,
    input logic       arst_n,
    input logic       cen,
    input logic       issue,
    input logic [3:0] cc,
    input logic       done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic issue_d1;     // issue seen on the last enabled edge.
    logic issue_d2;     // issue seen two enabled edges back.
    int   fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issue_d1 <= 1'b0;
            issue_d2 <= 1'b0;
        end else if (cen) begin
            issue_d1 <= issue;
            issue_d2 <= issue_d1;
        end
    end

    // done is the issue pulse delayed by exactly two enabled edges.
    done_latency: assert property (@(posedge clk) disable iff (!arst_n) done == issue_d2)
        else begin
            $error("done does not follow issue by two enabled edges");
            fail_count++;
        end

    done_in_reset: assert property (@(posedge clk) !arst_n |-> !done)
        else begin
            $error("done high during reset");
            fail_count++;
        end

    // flags only move on the edge that raises done.
    cc_hold: assert property (@(posedge clk) disable iff (!arst_n) !done |-> $stable(cc))
        else begin
            $error("cc changed without done");
            fail_count++;
        end

endmodule

bind m6805_exec m6805_exec_checker m6805_exec_checker_inst (.*);

// ==== tests/m6805_exec_monitor.sv ====
`include "m6805_params.svh"

module m6805_exec_monitor (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    cen,
    input  logic                    issue,
    input  m6805_pkg::alu_op_e      alu_sel,
    input  m6805_pkg::carry_sel_e   carry_sel,
    input  m6805_pkg::src_sel_e     src_sel,
    input  logic [`M6805_DW-1:0]    mem_data,
    input  logic [`M6805_DW-1:0]    imm,
    input  logic [`M6805_AW-1:0]    ea_base,
    input  logic [`M6805_AW-1:0]    result,
    input  logic [3:0]              cc,
    input  logic                    done,
    input  logic                    test_end,
    input  int                      test_num,
    input  logic                    run_end,
    output int                      errors,
    output int                      pending,
    output logic                    timeout
);
    timeunit 1ns;
    timeprecision 1ps;
    import m6805_pkg::*;

    logic [`M6805_AW+3:0] exp_q [$];  // expected result with the flags below it.
    logic [`M6805_AW+3:0] expv;
    logic [`M6805_AW-1:0] a;
    logic [`M6805_AW-1:0] b;
    logic [3:0]           flags;      // model of H, N, Z and C.
    int issued = 0;
    int cycles = 0;
    int checks = 0;
    int t_checks = 0;
    int t_errors = 0;
    int tests = 0;

    function automatic logic [3:0] update_mask(alu_op_e op, src_sel_e src);
        if (src == SRC_EA) return 4'b0000;  // address arithmetic.
        case (op)
            ADD_ALU: return 4'b1111;
            AND_ALU, OR_ALU, EOR_ALU: return 4'b0110;
            BSET_ALU, BCLR_ALU: return 4'b0001;
            default: return 4'b0111;            // sub, shifts and rotates.
        endcase
    endfunction

    // returns the 13-bit result followed by the updated flags.
    function automatic logic [`M6805_AW+3:0] exec_ref(alu_op_e op, carry_sel_e cs,
            logic [`M6805_AW-1:0] x, logic [`M6805_AW-1:0] y, logic [3:0] f, logic [3:0] m);
        logic [`M6805_AW-1:0] r;
        logic [3:0]           nf;
        logic                 cx;
        logic                 h;
        logic                 c;
        int                   s;
        cx = (cs == CIN_CARRY) ? f[0] : (cs == HI_CARRY);
        r  = x;
        h  = 1'b0;
        c  = 1'b0;
        s  = 0;
        case (op)
            ADD_ALU: begin
                r = x + y + {12'd0, cx};
                h = (int'(x[3:0]) + int'(y[3:0]) + int'(cx)) > 15;
                c = (int'(x[7:0]) + int'(y[7:0]) + int'(cx)) > 255;
            end
            SUB_ALU: begin
                s = int'(x[7:0]) - int'(y[7:0]) - int'(cx);
                r[7:0] = s[7:0];
                c = s < 0;  // borrow.
            end
            AND_ALU: r[7:0] = x[7:0] & y[7:0];
            OR_ALU:  r[7:0] = x[7:0] | y[7:0];
            EOR_ALU: r[7:0] = x[7:0] ^ y[7:0];
            ASR_ALU: begin
                r[7:0] = $signed(x[7:0]) >>> 1;  // sign bit stays in place.
                c      = x[0];
            end
            LSR_ALU: begin
                r[7:0] = (x[7:0] >> 1) | {cx, 7'd0};
                c      = x[0];
            end
            LSL_ALU: begin
                r[7:0] = x[7:0] << 1;
                c      = x[7];
            end
            ROL_ALU: begin
                r[7:0] = (x[7:0] << 1) | {7'd0, f[0]};  // rotates use the C flag itself.
                c      = x[7];
            end
            ROR_ALU: begin
                r[7:0] = (x[7:0] >> 1) | {f[0], 7'd0};
                c      = x[0];
            end
            BSET_ALU: begin
                c      = |(x[7:0] & (8'd1 << y[3:1]));
                r[7:0] = x[7:0] | (8'd1 << y[3:1]);
            end
            BCLR_ALU: begin
                c      = |(x[7:0] & (8'd1 << y[3:1]));
                r[7:0] = x[7:0] & ~(8'd1 << y[3:1]);
            end
            default: r = x;
        endcase
        nf = {h, r[7], r[7:0] == 8'd0, c};
        return {r, (nf & m) | (f & ~m)};
    endfunction

    task automatic note_error();
        errors++;
        t_errors++;
    endtask

    initial begin
        errors  = 0;
        pending = 0;
        timeout = 1'b0;
        flags   = '0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();  // anything in flight is lost.
            flags = '0;
        end else begin
            if (cen && done) begin
                if (exp_q.size() == 0) begin
                    $display("done pulse with no operation pending at %0t", $time);
                    note_error();
                end else begin
                    expv = exp_q.pop_front();
                    checks++;
                    t_checks++;
                    if (result !== expv[`M6805_AW+3:4]) begin
                        $display("ERROR result: expected %h got %h", expv[`M6805_AW+3:4], result);
                        note_error();
                    end
                    if (cc !== expv[3:0]) begin
                        $display("ERROR cc: expected %h got %h", expv[3:0], cc);
                        note_error();
                    end
                end
            end
            if (cen && issue) begin
                // operand forming as the input side does it.
                a = {5'd0, mem_data};
                b = {5'd0, imm};
                if (src_sel == SRC_EA) a = ea_base;
                if (src_sel == SRC_BIT) b = {9'd0, imm[2:0], 1'b0};
                if (src_sel == SRC_IMM) begin
                    a = {5'd0, imm};
                    b = {5'd0, mem_data};
                end
                expv  = exec_ref(alu_sel, carry_sel, a, b, flags,
                                 update_mask(alu_sel, src_sel));
                flags = expv[3:0];  // sequential model, results are in issue order.
                exp_q.push_back(expv);
                issued++;
            end
        end
        pending = exp_q.size();
    end

    always @(posedge clk) begin
        cycles++;
        if (!timeout && cycles > issued * 4 + 50) begin
            $display("timeout, %0d cycles for %0d operations", cycles, issued);
            timeout = 1'b1;
        end
    end

    always @(negedge clk) begin
        if (!arst_n && (result !== '0 || cc !== 4'd0 || done !== 1'b0)) begin
            $display("ERROR reset outputs: result %h cc %h done %h", result, cc, done);
            note_error();
        end
        if (test_end) begin
            $display("test %0d done, %0d checks, %0d errors", test_num, t_checks, t_errors);
            tests++;
            t_checks = 0;
            t_errors = 0;
        end
        if (run_end) $display("summary %0d tests, %0d checks, %0d errors", tests, checks, errors);
    end

endmodule

// ==== tests/m6805_exec_tb.sv ====
`include "m6805_params.svh"

module m6805_exec_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import m6805_pkg::*;

    logic clk, arst_n, cen, issue, test_end, run_end, timeout;
    alu_op_e              alu_sel;
    carry_sel_e           carry_sel;
    src_sel_e             src_sel;
    logic [`M6805_DW-1:0] mem_data, imm;
    logic [`M6805_AW-1:0] ea_base, result;
    logic [3:0]           cc;
    logic                 done;
    int test_num, errors, pending;
    int seed = 32'h7981_ba18;

    always #50 clk = ~clk;

    m6805_exec m6805_exec_inst (.*);
    m6805_exec_monitor m6805_exec_monitor_inst (.*);

    task automatic send_op(input alu_op_e op, input carry_sel_e cs, input src_sel_e src,
                           input logic [7:0] md, input logic [7:0] im, input logic [12:0] ea);
        @(posedge clk);
        cen       <= 1'b1;
        issue     <= 1'b1;
        alu_sel   <= op;
        carry_sel <= cs;
        src_sel   <= src;
        mem_data  <= md;
        imm       <= im;
        ea_base   <= ea;
    endtask

    task automatic finish_test(input int n);
        @(posedge clk);
        issue <= 1'b0;
        cen   <= 1'b1;
        do @(negedge clk); while (pending != 0);  // wait for every done.
        @(posedge clk);
        test_num <= n;
        test_end <= 1'b1;
        @(posedge clk);
        test_end <= 1'b0;
    endtask

    always @(posedge timeout) begin
        $display("Test failures found");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        cen       = 1'b0;
        issue     = 1'b0;
        test_end  = 1'b0;
        run_end   = 1'b0;
        alu_sel   = ADD_ALU;
        carry_sel = NO_CARRY;
        src_sel   = SRC_MEM;
        mem_data  = '0;
        imm       = '0;
        ea_base   = '0;
        test_num  = 0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        send_op(ADD_ALU, NO_CARRY, SRC_MEM, 8'h0f, 8'h01, 13'h0);   // half carry.
        send_op(ADD_ALU, NO_CARRY, SRC_IMM, 8'hf0, 8'h20, 13'h0);   // carry out.
        send_op(ADD_ALU, CIN_CARRY, SRC_MEM, 8'h10, 8'h10, 13'h0);
        send_op(ADD_ALU, HI_CARRY, SRC_MEM, 8'hff, 8'h00, 13'h0);
        send_op(ADD_ALU, HI_CARRY, SRC_EA, 8'h00, 8'h20, 13'h1ff0); // wraps, flags held.
        send_op(ADD_ALU, NO_CARRY, SRC_EA, 8'h00, 8'h44, 13'h0abc);
        finish_test(1);
        send_op(SUB_ALU, NO_CARRY, SRC_MEM, 8'h10, 8'h20, 13'h0);
        send_op(SUB_ALU, CIN_CARRY, SRC_IMM, 8'h05, 8'h40, 13'h0);
        send_op(AND_ALU, NO_CARRY, SRC_MEM, 8'hf0, 8'h0f, 13'h0);
        send_op(OR_ALU, NO_CARRY, SRC_MEM, 8'h80, 8'h01, 13'h0);
        send_op(EOR_ALU, NO_CARRY, SRC_MEM, 8'haa, 8'haa, 13'h0);
        finish_test(2);
        send_op(LSL_ALU, NO_CARRY, SRC_MEM, 8'h81, 8'h00, 13'h0);
        send_op(ASR_ALU, NO_CARRY, SRC_MEM, 8'h81, 8'h00, 13'h0);
        send_op(LSR_ALU, NO_CARRY, SRC_MEM, 8'h01, 8'h00, 13'h0);
        send_op(ROL_ALU, NO_CARRY, SRC_MEM, 8'h80, 8'h00, 13'h0);  // C out feeds the next.
        send_op(ROL_ALU, NO_CARRY, SRC_MEM, 8'h00, 8'h00, 13'h0);
        send_op(ROR_ALU, NO_CARRY, SRC_MEM, 8'h01, 8'h00, 13'h0);
        send_op(ROR_ALU, NO_CARRY, SRC_MEM, 8'h00, 8'h00, 13'h0);
        finish_test(3);
        for (int i = 0; i < 8; i++) begin
            send_op(BSET_ALU, NO_CARRY, SRC_BIT, 8'ha5, 8'(i), 13'h0);
            send_op(BCLR_ALU, NO_CARRY, SRC_BIT, 8'ha5, 8'(i), 13'h0);
        end
        finish_test(4);
        repeat (60) begin
            @(posedge clk);
            cen       <= ($random(seed) & 3) != 0;   // roughly one gap in four.
            issue     <= 1'($random(seed));
            alu_sel   <= alu_op_e'($unsigned($random(seed)) % 12);
            carry_sel <= carry_sel_e'($unsigned($random(seed)) % 3);
            src_sel   <= src_sel_e'($random(seed) & 3);
            mem_data  <= 8'($random(seed));
            imm       <= 8'($random(seed));
            ea_base   <= 13'($random(seed));
        end
        finish_test(5);
        send_op(ADD_ALU, HI_CARRY, SRC_MEM, 8'hff, 8'h80, 13'h0);
        send_op(ROL_ALU, NO_CARRY, SRC_MEM, 8'h80, 8'h00, 13'h0);
        send_op(SUB_ALU, NO_CARRY, SRC_MEM, 8'h00, 8'h01, 13'h0);
        @(posedge clk);
        arst_n <= 1'b0;  // two operations are still in flight.
        issue  <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        send_op(ROL_ALU, NO_CARRY, SRC_MEM, 8'h01, 8'h00, 13'h0);
        send_op(LSR_ALU, NO_CARRY, SRC_MEM, 8'h02, 8'h00, 13'h0);
        finish_test(6);
        @(posedge clk);
        run_end <= 1'b1;
        @(posedge clk);
        run_end <= 1'b0;
        @(posedge clk);
        if (errors == 0 && m6805_exec_inst.m6805_exec_checker_inst.fail_count == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+source
source/m6805_pkg.sv
source/m6805_operand_sel.sv
source/m6805_alu.sv
source/m6805_ccr.sv
source/m6805_exec.sv
tests/m6805_exec_checker.sv
tests/m6805_exec_monitor.sv
tests/m6805_exec_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= m6805_exec_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP BUILD_DIR LOG FILELIST"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
